//--- logic/video_timing_pkg.sv
// video timing package: raster geometry and position types
package video_timing_pkg;

	// raster position and pixel index types
	typedef logic [8:0] hcount_t;
	typedef logic [8:0] vcount_t;
	typedef logic [3:0] pixel_t;

	// line geometry, in c3 positions
	localparam int H_TOTAL    = 48;
	localparam int H_SYNC_END = 4;
	localparam int H_PIX_BEG  = 12;
	localparam int H_PIX_END  = 44;

	// frame geometry, in lines
	localparam int V_TOTAL    = 24;
	localparam int V_SYNC_END = 2;
	localparam int V_PIX_BEG  = 4;
	localparam int V_PIX_END  = 20;

	// first word request goes out this many positions before the pixel window
	localparam int FETCH_LEAD   = 8;

	// 16-colour bitmap, four nibbles per DRAM word
	localparam int PIX_PER_WORD = 4;

endpackage

//--- logic/video_regs_pkg.sv
// video register package: CPU register types, DRAM and palette types, reset values
package video_regs_pkg;

	// CPU register values
	typedef logic [7:0] reg8_t;
	typedef logic [8:0] vint_t;

	// DRAM word address and data
	typedef logic [20:0] dram_addr_t;
	typedef logic [15:0] dram_word_t;

	// palette RAM address and entry
	typedef logic [7:0] cram_addr_t;
	// red in 5:4, green in 3:2, blue in 1:0
	typedef logic [5:0] rgb_t;

	// bitmap words fetched per pixel line
	localparam int WORDS_PER_LINE = 8;

	// vconf bits
	localparam int VCONF_NOGFX_BIT = 0;

	// register reset values
	localparam reg8_t REG8_RST = 8'h00;
	localparam vint_t VINT_RST = 9'h000;

endpackage

//--- logic/video_ports.sv
// video ports: configuration registers loaded from the CPU data bus on write strobes
`timescale 1ns/10ps

module video_ports (
	input  logic                   clk,
	input  logic                   rst,
	input  video_regs_pkg::reg8_t  d,

	input  logic                   border_wr,
	input  logic                   vpage_wr,
	input  logic                   vconf_wr,
	input  logic                   palsel_wr,
	input  logic                   hint_beg_wr,
	input  logic                   vint_begl_wr,
	input  logic                   vint_begh_wr,

	output video_regs_pkg::reg8_t  border,
	output video_regs_pkg::reg8_t  vpage,
	output video_regs_pkg::reg8_t  vconf,
	output video_regs_pkg::reg8_t  palsel,
	output video_regs_pkg::reg8_t  hint_beg,
	output video_regs_pkg::vint_t  vint_beg
);

	always_ff @(posedge clk) begin
		if (rst) begin
			border   <= video_regs_pkg::REG8_RST;
			vpage    <= video_regs_pkg::REG8_RST;
			vconf    <= video_regs_pkg::REG8_RST;
			palsel   <= video_regs_pkg::REG8_RST;
			hint_beg <= video_regs_pkg::REG8_RST;
			vint_beg <= video_regs_pkg::VINT_RST;
		end else begin
			if (border_wr)
				border <= d;
			if (vpage_wr)
				vpage <= d;
			if (vconf_wr)
				vconf <= d;
			if (palsel_wr)
				palsel <= d;
			if (hint_beg_wr)
				hint_beg <= d;
			// interrupt line in two halves
			if (vint_begl_wr)
				vint_beg[7:0] <= d;
			// high half is only the line msb
			if (vint_begh_wr)
				vint_beg[8] <= d[0];
		end
	end

endmodule

//--- logic/video_sync.sv
// video sync: raster counters, sync and blank decode, pixel window and line strobes
`timescale 1ns/10ps

module video_sync (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       c3,
	input  video_regs_pkg::reg8_t      hint_beg,
	input  video_regs_pkg::vint_t      vint_beg,

	output video_timing_pkg::hcount_t  hcount,
	output video_timing_pkg::vcount_t  vcount,
	output logic                       hsync,
	output logic                       vsync,
	output logic                       csync,
	output logic                       blank,
	output logic                       hvpix,
	output logic                       fetch_line,
	output logic                       line_start,
	output logic                       frame_start,
	output logic                       int_start
);

	video_timing_pkg::hcount_t h_next;
	video_timing_pkg::vcount_t v_next;
	video_timing_pkg::hcount_t int_pos;
	logic h_wrap;
	logic hs_next;
	logic vs_next;
	logic hpix_next;
	logic vpix_next;

	// position entered at the next c3
	assign h_wrap = hcount == video_timing_pkg::hcount_t'(video_timing_pkg::H_TOTAL - 1);
	assign h_next = h_wrap ? '0 : hcount + 1'b1;

	always_comb begin
		v_next = vcount;
		if (h_wrap)
			v_next = (vcount == video_timing_pkg::vcount_t'(video_timing_pkg::V_TOTAL - 1)) ?
				'0 : vcount + 1'b1;
	end

	assign hs_next = h_next < video_timing_pkg::hcount_t'(video_timing_pkg::H_SYNC_END);
	assign vs_next = v_next < video_timing_pkg::vcount_t'(video_timing_pkg::V_SYNC_END);

	assign hpix_next = (h_next >= video_timing_pkg::hcount_t'(video_timing_pkg::H_PIX_BEG)) &&
		(h_next < video_timing_pkg::hcount_t'(video_timing_pkg::H_PIX_END));
	assign vpix_next = (v_next >= video_timing_pkg::vcount_t'(video_timing_pkg::V_PIX_BEG)) &&
		(v_next < video_timing_pkg::vcount_t'(video_timing_pkg::V_PIX_END));

	// hint_beg counts in pairs of positions
	assign int_pos = {hint_beg, 1'b0};

	always_ff @(posedge clk) begin
		if (rst) begin
			hcount      <= '0;
			vcount      <= '0;
			hsync       <= 1'b0;
			vsync       <= 1'b0;
			csync       <= 1'b0;
			blank       <= 1'b1;
			hvpix       <= 1'b0;
			fetch_line  <= 1'b0;
			line_start  <= 1'b0;
			frame_start <= 1'b0;
			int_start   <= 1'b0;
		end else if (c3) begin
			hcount     <= h_next;
			vcount     <= v_next;
			hsync      <= hs_next;
			vsync      <= vs_next;
			csync      <= vs_next ? ~(hs_next ^ vs_next) : hs_next;
			// only the sync intervals are blanked
			blank      <= hs_next || vs_next;
			hvpix      <= hpix_next && vpix_next;
			fetch_line <= vpix_next;
			// line strobe marks the fetch lead point, not column 0
			line_start <= h_next == video_timing_pkg::hcount_t'(
				video_timing_pkg::H_PIX_BEG - video_timing_pkg::FETCH_LEAD);
			frame_start <= (h_next == '0) && (v_next == '0);
			int_start   <= (h_next == int_pos) && (v_next == vint_beg);
		end else begin
			line_start  <= 1'b0;
			frame_start <= 1'b0;
			int_start   <= 1'b0;
		end
	end

endmodule

//--- logic/video_fetch.sv
// video fetch: bitmap word requests to DRAM with one word of look-ahead and nibble shifter
`timescale 1ns/10ps

module video_fetch (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           c3,
	input  logic                           hvpix,
	input  logic                           line_start,
	input  logic                           fetch_line,
	input  video_timing_pkg::vcount_t      vcount,
	input  video_regs_pkg::reg8_t          vpage,
	input  logic                           video_strobe,
	input  video_regs_pkg::dram_word_t     dram_rddata,

	output logic                           video_go,
	output video_regs_pkg::dram_addr_t     video_addr,
	output video_timing_pkg::pixel_t       pixel
);

	typedef enum logic [1:0] {fetch_idle, fetch_wait, fetch_full} fetch_state_t;

	fetch_state_t state;
	video_regs_pkg::dram_word_t pref;
	video_regs_pkg::dram_word_t shreg;
	video_regs_pkg::dram_word_t word_in;
	video_regs_pkg::dram_addr_t line_base;
	logic [1:0] nib_cnt;
	logic [3:0] word_cnt;
	logic [3:0] word_idx;
	logic sh_valid;
	logic word_rdy;
	logic line_go;
	logic last_nib;
	logic shift;
	logic load;
	logic more;
	logic issue;

	// returning word is taken straight from the bus when needed at once
	assign word_rdy = (state == fetch_full) || ((state == fetch_wait) && video_strobe);
	assign word_in  = (state == fetch_full) ? pref : dram_rddata;

	assign line_go  = line_start && fetch_line;
	assign last_nib = nib_cnt == 2'(video_timing_pkg::PIX_PER_WORD - 1);
	assign shift    = sh_valid && c3 && hvpix;
	// reload after the last nibble, or fill an empty shifter before the first pixel
	assign load     = !line_start && word_rdy && (sh_valid ? (shift && last_nib) : 1'b1);
	assign more     = word_cnt < 4'(video_regs_pkg::WORDS_PER_LINE);
	assign issue    = line_go || (load && more);
	assign word_idx = line_start ? 4'd0 : word_cnt;

	assign line_base = video_regs_pkg::dram_addr_t'({vpage, 7'd0}) +
		video_regs_pkg::dram_addr_t'((vcount - video_timing_pkg::vcount_t'(
		video_timing_pkg::V_PIX_BEG)) * video_regs_pkg::WORDS_PER_LINE);

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= fetch_idle;
			sh_valid <= 1'b0;
			nib_cnt  <= '0;
			word_cnt <= '0;
			video_go <= 1'b0;
		end else begin
			video_go <= issue;
			if (issue)
				word_cnt <= word_idx + 1'b1;
			if (line_start) begin
				sh_valid <= 1'b0;
				nib_cnt  <= '0;
				state    <= line_go ? fetch_wait : fetch_idle;
			end else if (load) begin
				sh_valid <= 1'b1;
				nib_cnt  <= '0;
				state    <= more ? fetch_wait : fetch_idle;
			end else begin
				if ((state == fetch_wait) && video_strobe)
					state <= fetch_full;
				// out of words, shifter runs dry
				if (shift) begin
					nib_cnt <= nib_cnt + 1'b1;
					if (last_nib)
						sh_valid <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (issue)
			video_addr <= line_base + video_regs_pkg::dram_addr_t'(word_idx);
		if ((state == fetch_wait) && video_strobe)
			pref <= dram_rddata;
		if (load)
			shreg <= word_in;
		else if (shift)
			shreg <= {shreg[11:0], 4'd0};
	end

	// high nibble is shown first
	assign pixel = shreg[15:12];

endmodule

//--- logic/video_out.sv
// video out: border or pixel select, palette RAM lookup and registered colour outputs
`timescale 1ns/10ps

module video_out (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          blank,
	input  logic                          hvpix,
	input  video_regs_pkg::reg8_t         vconf,
	input  video_regs_pkg::reg8_t         border,
	input  video_regs_pkg::reg8_t         palsel,
	input  video_timing_pkg::pixel_t      pixel,

	input  logic                          cram_we,
	input  video_regs_pkg::cram_addr_t    cram_addr,
	input  video_regs_pkg::rgb_t          cram_data,

	output logic [1:0]                    vred,
	output logic [1:0]                    vgrn,
	output logic [1:0]                    vblu
);

	video_regs_pkg::rgb_t cram [0:255];
	video_regs_pkg::cram_addr_t idx;
	video_regs_pkg::rgb_t colour;
	logic nogfx;

	assign nogfx = vconf[video_regs_pkg::VCONF_NOGFX_BIT];

	// pixel window uses the palette group from palsel, else border entry
	assign idx = (hvpix && !nogfx) ? {palsel[3:0], pixel} : border;

	always_ff @(posedge clk) begin
		if (cram_we)
			cram[cram_addr] <= cram_data;
	end

	always_ff @(posedge clk) begin
		if (rst)
			colour <= '0;
		else if (blank)
			colour <= '0;
		else
			colour <= cram[idx];
	end

	assign vred = colour[5:4];
	assign vgrn = colour[3:2];
	assign vblu = colour[1:0];

endmodule

//--- logic/video_top.sv
// video top: port registers, raster sync, bitmap fetch and palette output
`timescale 1ns/10ps

module video_top (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          c3,
	input  video_regs_pkg::reg8_t         d,

	input  logic                          border_wr,
	input  logic                          vpage_wr,
	input  logic                          vconf_wr,
	input  logic                          palsel_wr,
	input  logic                          hint_beg_wr,
	input  logic                          vint_begl_wr,
	input  logic                          vint_begh_wr,

	input  logic [15:0]                   a,
	input  logic [15:0]                   fd,
	input  logic                          cram_we,

	input  video_regs_pkg::dram_word_t    dram_rddata,
	input  logic                          video_strobe,
	output logic                          video_go,
	output video_regs_pkg::dram_addr_t    video_addr,

	output logic                          hsync,
	output logic                          vsync,
	output logic                          csync,
	output logic                          int_start,

	output logic [1:0]                    vred,
	output logic [1:0]                    vgrn,
	output logic [1:0]                    vblu
);

	// registers
	video_regs_pkg::reg8_t border;
	video_regs_pkg::reg8_t vpage;
	video_regs_pkg::reg8_t vconf;
	video_regs_pkg::reg8_t palsel;
	video_regs_pkg::reg8_t hint_beg;
	video_regs_pkg::vint_t vint_beg;

	// raster
	video_timing_pkg::vcount_t vcount;
	logic blank;
	logic hvpix;
	logic fetch_line;
	logic line_start;

	video_timing_pkg::pixel_t pixel;

	video_ports video_ports_i (
		.clk          (clk),
		.rst          (rst),
		.d            (d),
		.border_wr    (border_wr),
		.vpage_wr     (vpage_wr),
		.vconf_wr     (vconf_wr),
		.palsel_wr    (palsel_wr),
		.hint_beg_wr  (hint_beg_wr),
		.vint_begl_wr (vint_begl_wr),
		.vint_begh_wr (vint_begh_wr),
		.border       (border),
		.vpage        (vpage),
		.vconf        (vconf),
		.palsel       (palsel),
		.hint_beg     (hint_beg),
		.vint_beg     (vint_beg)
	);

	video_sync video_sync_i (
		.clk         (clk),
		.rst         (rst),
		.c3          (c3),
		.hint_beg    (hint_beg),
		.vint_beg    (vint_beg),
		.hcount      (),
		.vcount      (vcount),
		.hsync       (hsync),
		.vsync       (vsync),
		.csync       (csync),
		.blank       (blank),
		.hvpix       (hvpix),
		.fetch_line  (fetch_line),
		.line_start  (line_start),
		.frame_start (),
		.int_start   (int_start)
	);

	// nogfx keeps the fetcher off for the whole frame
	video_fetch video_fetch_i (
		.clk          (clk),
		.rst          (rst),
		.c3           (c3),
		.hvpix        (hvpix),
		.line_start   (line_start),
		.fetch_line   (fetch_line & ~vconf[video_regs_pkg::VCONF_NOGFX_BIT]),
		.vcount       (vcount),
		.vpage        (vpage),
		.video_strobe (video_strobe),
		.dram_rddata  (dram_rddata),
		.video_go     (video_go),
		.video_addr   (video_addr),
		.pixel        (pixel)
	);

	video_out video_out_i (
		.clk       (clk),
		.rst       (rst),
		.blank     (blank),
		.hvpix     (hvpix),
		.vconf     (vconf),
		.border    (border),
		.palsel    (palsel),
		.pixel     (pixel),
		.cram_we   (cram_we),
		.cram_addr (a[8:1]),
		.cram_data (fd[5:0]),
		.vred      (vred),
		.vgrn      (vgrn),
		.vblu      (vblu)
	);

endmodule

//--- tb/video_checker.sv
// video checker: DRAM handshake, interrupt strobe and hsync window assertions
`timescale 1ns/10ps

module video_checker (
	input logic                       clk,
	input logic                       rst,
	input logic                       c3,
	input logic                       video_go,
	input logic                       video_strobe,
	input logic                       int_start,
	input logic                       hsync
);

	logic outst;
	logic [3:0] wait_cnt;
	video_timing_pkg::hcount_t hpos;
	int fail_cnt = 0;

	always_ff @(posedge clk) begin
		if (rst) begin
			outst <= 1'b0;
			wait_cnt <= '0;
		end else if (video_go) begin
			outst <= 1'b1;
			wait_cnt <= '0;
		end else if (video_strobe)
			outst <= 1'b0;
		else if (outst)
			wait_cnt <= wait_cnt + 1'b1;
	end

	// own line position, one step per c3
	always_ff @(posedge clk) begin
		if (rst)
			hpos <= '0;
		else if (c3)
			hpos <= (hpos == video_timing_pkg::hcount_t'(video_timing_pkg::H_TOTAL - 1)) ?
				'0 : hpos + 1'b1;
	end

	// one request in flight
	a_one_req: assert property (@(posedge clk) disable iff (rst) video_go |-> !outst)
		else begin
			$error("video_go while a request is outstanding");
			fail_cnt++;
		end

	// answer within 2*PIX_PER_WORD-1 clk
	a_latency: assert property (@(posedge clk) disable iff (rst)
		!(outst && wait_cnt >= 4'(2 * video_timing_pkg::PIX_PER_WORD - 1)))
		else begin
			$error("video_strobe late");
			fail_cnt++;
		end

	a_int_width: assert property (@(posedge clk) disable iff (rst) int_start |=> !int_start)
		else begin
			$error("int_start wider than one cycle");
			fail_cnt++;
		end

	a_hsync_win: assert property (@(posedge clk) disable iff (rst)
		(hpos >= video_timing_pkg::hcount_t'(video_timing_pkg::H_SYNC_END)) |-> !hsync)
		else begin
			$error("hsync high outside its window");
			fail_cnt++;
		end

endmodule

bind video_top video_checker video_checker_i (
	.clk          (clk),
	.rst          (rst),
	.c3           (c3),
	.video_go     (video_go),
	.video_strobe (video_strobe),
	.int_start    (int_start),
	.hsync        (hsync)
);

//--- tb/video_tb.sv
// video testbench: case replay, DRAM responder and raster reference model
`timescale 1ns/10ps

module video_tb;

	localparam int H_TOTAL     = video_timing_pkg::H_TOTAL;
	localparam int V_TOTAL     = video_timing_pkg::V_TOTAL;
	localparam int H_PIX_BEG   = video_timing_pkg::H_PIX_BEG;
	localparam int H_PIX_END   = video_timing_pkg::H_PIX_END;
	localparam int V_PIX_BEG   = video_timing_pkg::V_PIX_BEG;
	localparam int V_PIX_END   = video_timing_pkg::V_PIX_END;
	localparam int NIBS        = video_timing_pkg::PIX_PER_WORD;
	localparam int WORDS       = video_regs_pkg::WORDS_PER_LINE;
	localparam int FRAME_CLK   = H_TOTAL * V_TOTAL * 2;
	localparam int GO_PER_FRAME = (V_PIX_END - V_PIX_BEG) * WORDS;

	logic clk, rst, c3;
	video_regs_pkg::reg8_t d;
	logic border_wr, vpage_wr, vconf_wr, palsel_wr, hint_beg_wr, vint_begl_wr, vint_begh_wr;
	logic [15:0] a, fd;
	logic cram_we;
	video_regs_pkg::dram_word_t dram_rddata;
	logic video_strobe, video_go;
	video_regs_pkg::dram_addr_t video_addr;
	logic hsync, vsync, csync, int_start;
	logic [1:0] vred, vgrn, vblu;

	// case records
	string q_op[$];
	string q_name[$];
	int q_v1[$];
	int q_v2[$];
	int total_frames;

	string cur_test = "setup";
	int errors;
	int cycles;
	int limit;
	int go_cnt;
	int int_cnt;

	// reference model state
	int mh, mv, mframes;
	logic started;
	logic [5:0] col_exp;
	logic int_exp;
	video_regs_pkg::reg8_t r_border, r_vpage, r_vconf, r_palsel, r_hint;
	video_regs_pkg::vint_t r_vint;
	logic [5:0] pal [0:255];
	int nh, nv;
	logic hs_exp;
	logic vs_exp;
	logic cs_exp;

	// rsp side
	logic pend;
	int lat;
	int line_words;
	video_regs_pkg::dram_addr_t rsp_addr;

	video_top video_top_i (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
		c3 <= ~c3;

	function automatic logic [15:0] dram_word(input int unsigned addr);
		int unsigned prod;
		prod = addr * 32'd40503;
		return prod[15:0];
	endfunction

	function automatic logic [5:0] predict_colour();
		int c;
		int unsigned addr;
		logic [15:0] w;
		logic [3:0] nib;
		logic pix;
		pix = (mh >= H_PIX_BEG) && (mh < H_PIX_END) && (mv >= V_PIX_BEG) && (mv < V_PIX_END);
		if (!started || (mh < video_timing_pkg::H_SYNC_END) ||
				(mv < video_timing_pkg::V_SYNC_END))
			return 6'd0;
		if (pix && !r_vconf[video_regs_pkg::VCONF_NOGFX_BIT]) begin
			c = mh - H_PIX_BEG;
			addr = int'(r_vpage) * 128 + (mv - V_PIX_BEG) * WORDS + c / NIBS;
			w = dram_word(addr);
			// high nibble first
			nib = w[4 * (NIBS - 1 - c % NIBS) +: 4];
			return pal[{r_palsel[3:0], nib}];
		end
		return pal[r_border];
	endfunction

	task automatic check(input string what, input int exp, input int act);
		if (exp != act) begin
			$display("ERROR %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
			errors++;
		end
	endtask

	assign nh = (mh == H_TOTAL - 1) ? 0 : mh + 1;
	assign nv = (mh != H_TOTAL - 1) ? mv : ((mv == V_TOTAL - 1) ? 0 : mv + 1);

	always @(posedge clk) begin
		if (rst) begin
			mh <= 0;
			mv <= 0;
			mframes <= 0;
			started <= 1'b0;
			col_exp <= 6'd0;
			int_exp <= 1'b0;
			r_border <= '0;
			r_vpage <= '0;
			r_vconf <= '0;
			r_palsel <= '0;
			r_hint <= '0;
			r_vint <= '0;
		end else begin
			col_exp <= predict_colour();
			if (c3) begin
				started <= 1'b1;
				mh <= nh;
				mv <= nv;
				int_exp <= (nh == 2 * int'(r_hint)) && (nv == int'(r_vint));
				if (nh == 0 && nv == 0)
					mframes <= mframes + 1;
			end else
				int_exp <= 1'b0;
			if (border_wr) r_border <= d;
			if (vpage_wr) r_vpage <= d;
			if (vconf_wr) r_vconf <= d;
			if (palsel_wr) r_palsel <= d;
			if (hint_beg_wr) r_hint <= d;
			if (vint_begl_wr) r_vint[7:0] <= d;
			if (vint_begh_wr) r_vint[8] <= d[0];
		end
		if (cram_we)
			pal[a[8:1]] <= fd[5:0];
	end

	// DRAM responder, one request at a time
	always @(posedge clk) begin
		video_strobe <= 1'b0;
		if (rst) begin
			pend <= 1'b0;
			line_words <= 0;
		end else if (video_go) begin
			check("video_addr", int'(r_vpage) * 128 + (mv - V_PIX_BEG) * WORDS + line_words,
				int'(video_addr));
			pend <= 1'b1;
			line_words <= line_words + 1;
			rsp_addr <= video_addr;
			lat <= 1 + int'($urandom % 3);
		end else if (pend) begin
			if (lat <= 1) begin
				video_strobe <= 1'b1;
				dram_rddata <= dram_word(int'(rsp_addr));
				pend <= 1'b0;
			end else
				lat <= lat - 1;
		end
		// word index restarts with each line
		if (c3 && nh == 0)
			line_words <= 0;
	end

	always @(negedge clk) begin
		if (!rst) begin
			hs_exp = started && mh < video_timing_pkg::H_SYNC_END;
			vs_exp = started && mv < video_timing_pkg::V_SYNC_END;
			// xnor during vsync, plain hsync otherwise
			cs_exp = vs_exp ? ~(hs_exp ^ vs_exp) : hs_exp;
			check("hsync", int'(hs_exp), int'(hsync));
			check("vsync", int'(vs_exp), int'(vsync));
			check("csync", int'(cs_exp), int'(csync));
			check("int_start", int'(int_exp), int'(int_start));
			check("colour", int'(col_exp), int'({vred, vgrn, vblu}));
			go_cnt += int'(video_go);
			int_cnt += int'(int_start);
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles >= limit) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic load_cases(output logic ok);
		int fh;
		int n;
		int v1;
		int v2;
		string tok;
		string name;
		string rest;
		ok = 1'b0;
		total_frames = 0;
		fh = $fopen("tb/video_cases.txt", "r");
		if (fh != 0) begin
			ok = 1'b1;
			while (!$feof(fh)) begin
				n = $fscanf(fh, "%s", tok);
				if (n != 1)
					break;
				v1 = 0;
				v2 = 0;
				name = "";
				if (tok.getc(0) == "#")
					n = $fgets(rest, fh);
				else if (tok == "reg")
					n = $fscanf(fh, " %s %h", name, v1);
				else if (tok == "pal")
					n = $fscanf(fh, " %h %h", v1, v2);
				else if (tok == "run") begin
					n = $fscanf(fh, " %d %s", v1, name);
					total_frames += v1;
				end
				if (tok.getc(0) != "#") begin
					q_op.push_back(tok);
					q_name.push_back(name);
					q_v1.push_back(v1);
					q_v2.push_back(v2);
				end
			end
			$fclose(fh);
		end
	endtask

	task automatic write_reg(input string name, input int value);
		@(posedge clk);
		d <= 8'(value);
		case (name)
			"border": border_wr <= 1'b1;
			"vpage": vpage_wr <= 1'b1;
			"vconf": vconf_wr <= 1'b1;
			"palsel": palsel_wr <= 1'b1;
			"hint_beg": hint_beg_wr <= 1'b1;
			"vint_begl": vint_begl_wr <= 1'b1;
			"vint_begh": vint_begh_wr <= 1'b1;
			default: begin
				$display("case file names an unknown register %s", name);
				errors++;
			end
		endcase
		@(posedge clk);
		{border_wr, vpage_wr, vconf_wr, palsel_wr} <= 4'b0;
		{hint_beg_wr, vint_begl_wr, vint_begh_wr} <= 3'b0;
	endtask

	task automatic write_pal(input int idx, input int rgb);
		@(posedge clk);
		a <= 16'(idx * 2);
		fd <= 16'(rgb);
		cram_we <= 1'b1;
		@(posedge clk);
		cram_we <= 1'b0;
	endtask

	task automatic clear_palette();
		for (int i = 0; i < 256; i++) begin
			@(posedge clk);
			a <= 16'(i * 2);
			fd <= 16'd0;
			cram_we <= 1'b1;
		end
		@(posedge clk);
		cram_we <= 1'b0;
	endtask

	task automatic run_frames(input int n, input string name);
		int target;
		int exp_go;
		cur_test = name;
		target = mframes + n;
		exp_go = r_vconf[video_regs_pkg::VCONF_NOGFX_BIT] ? 0 : n * GO_PER_FRAME;
		go_cnt = 0;
		int_cnt = 0;
		while (mframes != target)
			@(posedge clk);
		check("video_go count", exp_go, go_cnt);
		check("int_start count", n, int_cnt);
	endtask

	initial begin
		logic ok;
		int total;
		rst = 1'b1;
		c3 = 1'b0;
		d = '0;
		{border_wr, vpage_wr, vconf_wr, palsel_wr} = 4'b0;
		{hint_beg_wr, vint_begl_wr, vint_begh_wr} = 3'b0;
		a = '0;
		fd = '0;
		cram_we = 1'b0;
		dram_rddata = '0;
		video_strobe = 1'b0;
		errors = 0;
		cycles = 0;
		limit = 0;
		go_cnt = 0;
		int_cnt = 0;
		void'($urandom(37738));
		load_cases(ok);
		if (!ok) begin
			$display("could not open tb/video_cases.txt");
			$display("TESTBENCH FAILED");
			$finish;
		end else begin
			limit = total_frames * FRAME_CLK + 1000;
			repeat (4) @(posedge clk);
			rst <= 1'b0;
			clear_palette();
			foreach (q_op[i]) begin
				if (q_op[i] == "reg")
					write_reg(q_name[i], q_v1[i]);
				else if (q_op[i] == "pal")
					write_pal(q_v1[i], q_v2[i]);
				else if (q_op[i] == "run")
					run_frames(q_v1[i], q_name[i]);
			end
			total = errors + video_top_i.video_checker_i.fail_cnt;
			$display("errors: %0d checks, %0d assertions", errors,
				video_top_i.video_checker_i.fail_cnt);
			if (total == 0)
				$display("TESTBENCH PASSED");
			else
				$display("TESTBENCH FAILED");
			$finish;
		end
	end

endmodule

//--- tb/video_cases.txt
# record per line, values in hex except the frame count
# reg <register> <value> | pal <index> <rgb> | run <frames> <test name>
run 1 reset_idle
pal 07 2d
pal 31 3f
pal 3a 15
pal 3f 2a
pal 30 01
reg border 07
reg palsel 03
reg hint_beg 0a
reg vint_begl 06
run 2 border_pixels
reg vpage 2a
pal 34 11
pal 3c 33
run 1 pixels_vpage2a
reg vconf 01
reg border 3f
run 1 nogfx_border
reg vconf 00
reg hint_beg 15
reg vint_begl 13
reg vint_begh 00
run 2 int_moved

//--- sources.f
logic/video_timing_pkg.sv
logic/video_regs_pkg.sv
logic/video_ports.sv
logic/video_sync.sv
logic/video_fetch.sv
logic/video_out.sv
logic/video_top.sv
tb/video_checker.sv
tb/video_tb.sv

//--- run.sh
#!/bin/sh
# build and run the video testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module video_tb -Mdir obj_dir -o video_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/video_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
	exit 1
fi
exit 0
